// ==== src/i2c_pkg.sv ====
package i2c_pkg;

    ////////////////////////////////////////
    // data widths
    ////////////////////////////////////////

    typedef logic [7:0] data_t;       // one bus or register byte
    typedef logic [6:0] dev_addr_t;   // 7-bit slave address
    typedef logic [7:0] word_addr_t;  // offset inside the eeprom
    typedef logic [2:0] reg_addr_t;   // wishbone register index

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////

    localparam reg_addr_t reg_dev_addr  = 3'd0;
    localparam reg_addr_t reg_word_addr = 3'd1;
    localparam reg_addr_t reg_wdata     = 3'd2;
    localparam reg_addr_t reg_ctrl      = 3'd3;
    localparam reg_addr_t reg_status    = 3'd4;
    localparam reg_addr_t reg_rdata     = 3'd5;

    // control register bits
    localparam int ctrl_go_bit   = 0;  // write 1 to launch
    localparam int ctrl_read_bit = 1;  // 1 = random read, 0 = byte write

    // status register bits
    localparam int status_busy_bit  = 0;
    localparam int status_done_bit  = 1;  // sticky
    localparam int status_error_bit = 2;  // sticky, slave nacked

    ////////////////////////////////////////
    // bit engine commands
    ////////////////////////////////////////

    // start doubles as repeated start when scl is already low
    typedef enum logic [1:0] {
        cmd_start,
        cmd_stop,
        cmd_write,  // 8 bits out, ack sampled on the 9th
        cmd_read    // 8 bits in, nack driven on the 9th
    } bit_cmd_t;

endpackage

// ==== src/i2c_regs.sv ====
module i2c_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  i2c_pkg::reg_addr_t     wb_adr,
    input  i2c_pkg::data_t         wb_dat_w,
    output i2c_pkg::data_t         wb_dat_r,
    output logic                   wb_ack,
    output logic                   go,
    output logic                   is_read,
    output i2c_pkg::dev_addr_t     dev_addr,
    output i2c_pkg::word_addr_t    word_addr,
    output i2c_pkg::data_t         wdata,
    input  logic                   xfer_done,
    input  logic                   xfer_error,
    input  i2c_pkg::data_t         rdata
);

    logic           busy;
    logic           done;
    logic           error;
    i2c_pkg::data_t rdata_q;   // last byte from a random read
    logic           wr;        // write accepted in the ack cycle
    logic           cfg_wr;    // settings are frozen while busy

    assign wr     = wb_ack & wb_we;
    assign cfg_wr = wr & ~busy;

    // control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack  <= 1'b0;
            go      <= 1'b0;
            is_read <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
            rdata_q <= '0;
        end else begin
            wb_ack <= wb_cyc & wb_stb & ~wb_ack;  // one-cycle ack, gap before the next
            go     <= cfg_wr && (wb_adr == i2c_pkg::reg_ctrl) && wb_dat_w[i2c_pkg::ctrl_go_bit];
            if (cfg_wr && wb_adr == i2c_pkg::reg_ctrl)
                is_read <= wb_dat_w[i2c_pkg::ctrl_read_bit];
            if (go) begin
                busy  <= 1'b1;
                done  <= 1'b0;   // next start clears the sticky flags
                error <= 1'b0;
            end else if (xfer_done || xfer_error) begin
                busy  <= 1'b0;
                done  <= xfer_done;
                error <= xfer_error;
            end
            if (xfer_done && is_read)
                rdata_q <= rdata;
        end
    end

    // transaction settings
    always_ff @(posedge clk) begin
        if (cfg_wr && wb_adr == i2c_pkg::reg_dev_addr)  dev_addr  <= wb_dat_w[6:0];
        if (cfg_wr && wb_adr == i2c_pkg::reg_word_addr) word_addr <= wb_dat_w;
        if (cfg_wr && wb_adr == i2c_pkg::reg_wdata)     wdata     <= wb_dat_w;
    end

    // read-back, valid while ack is high
    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            i2c_pkg::reg_dev_addr:  wb_dat_r = {1'b0, dev_addr};
            i2c_pkg::reg_word_addr: wb_dat_r = word_addr;
            i2c_pkg::reg_wdata:     wb_dat_r = wdata;
            i2c_pkg::reg_ctrl:      wb_dat_r[i2c_pkg::ctrl_read_bit] = is_read;
            i2c_pkg::reg_status: begin
                wb_dat_r[i2c_pkg::status_busy_bit]  = busy;
                wb_dat_r[i2c_pkg::status_done_bit]  = done;
                wb_dat_r[i2c_pkg::status_error_bit] = error;
            end
            i2c_pkg::reg_rdata:     wb_dat_r = rdata_q;
            default:                wb_dat_r = '0;
        endcase
    end

    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack);
    go_idle:    assert property (@(posedge clk) disable iff (reset) go |-> !busy);

endmodule

// ==== src/i2c_bit_engine.sv ====
module i2c_bit_engine #(
    parameter int clk_div = 4   // clk cycles per quarter scl period
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  i2c_pkg::bit_cmd_t cmd,
    input  i2c_pkg::data_t    tx_byte,
    output logic              cmd_done,
    output logic              nack,
    output i2c_pkg::data_t    rx_byte,
    input  logic              sda_in,
    input  logic              scl_in,
    output logic              scl_oe,
    output logic              sda_oe
);

    localparam int cnt_w = $clog2(clk_div);

    typedef enum logic [1:0] {
        ph_idle,
        ph_start,
        ph_stop,
        ph_bit
    } phase_t;

    phase_t         phase;
    logic [cnt_w-1:0] qcnt;     // cycles within a quarter
    logic [1:0]     q;          // quarter within a bit or condition
    logic [3:0]     bit_cnt;    // 0..7 data, 8 = acknowledge
    logic           rd_mode;
    i2c_pkg::data_t tx_sr;
    logic           tick;
    logic           accept;
    logic           sample;
    logic           shift;
    logic           scl_nxt;
    logic           sda_nxt;

    assign tick   = (qcnt == cnt_w'(clk_div - 1));
    assign accept = (phase == ph_idle) && cmd_valid;
    assign sample = (phase == ph_bit) && tick && (q == 2'd2);  // middle of scl high
    assign shift  = (phase == ph_bit) && tick && (q == 2'd3);

    ////////////////////////////////////////
    // line levels per quarter
    ////////////////////////////////////////

    always_comb begin
        scl_nxt = scl_oe;   // idle holds the bus as it was left
        sda_nxt = sda_oe;
        case (phase)
            ph_start: begin
                scl_nxt = (q == 2'd0);          // low first so a restart is clean
                sda_nxt = (q >= 2'd2);          // sda falls with scl high
            end
            ph_stop: begin
                scl_nxt = (q <= 2'd1);
                if (q != 2'd0)
                    sda_nxt = (q != 2'd3);      // sda rises with scl high
            end
            ph_bit: begin
                scl_nxt = (q <= 2'd1);
                if (q != 2'd0)                  // change sda one quarter after scl fell
                    sda_nxt = !rd_mode && (bit_cnt != 4'd8) && !tx_sr[7];
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase    <= ph_idle;
            qcnt     <= '0;
            q        <= 2'd0;
            bit_cnt  <= 4'd0;
            rd_mode  <= 1'b0;
            cmd_done <= 1'b0;
            nack     <= 1'b0;
            scl_oe   <= 1'b0;
            sda_oe   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            scl_oe   <= scl_nxt;
            sda_oe   <= sda_nxt;
            if (accept) begin
                qcnt    <= '0;
                q       <= 2'd0;
                bit_cnt <= 4'd0;
                rd_mode <= (cmd == i2c_pkg::cmd_read);
                case (cmd)
                    i2c_pkg::cmd_start: phase <= ph_start;
                    i2c_pkg::cmd_stop:  phase <= ph_stop;
                    default:            phase <= ph_bit;
                endcase
            end else if (phase != ph_idle) begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                    q <= q + 2'd1;
                if (sample && bit_cnt == 4'd8 && !rd_mode)
                    nack <= sda_in;             // high = no slave ack
                if (tick && q == 2'd3) begin
                    if (phase == ph_bit && bit_cnt != 4'd8) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end else begin
                        phase    <= ph_idle;
                        cmd_done <= 1'b1;
                    end
                end
            end
        end
    end

    // data shift registers
    always_ff @(posedge clk) begin
        if (accept)
            tx_sr <= tx_byte;
        else if (shift)
            tx_sr <= {tx_sr[6:0], 1'b0};        // msb first
        if (sample && rd_mode && bit_cnt != 4'd8)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

    // sda moves only under a low scl, except for start and stop conditions
    sda_stable: assert property (@(posedge clk) disable iff (reset)
        $changed(sda_oe) && !(phase inside {ph_start, ph_stop}) |-> scl_oe && $past(scl_oe));

    // nothing else may release scl while the master holds it low
    scl_held: assert property (@(posedge clk) disable iff (reset) scl_oe |-> !scl_in);

endmodule

// ==== src/i2c_sequencer.sv ====
module i2c_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                go,
    input  logic                is_read,
    input  i2c_pkg::dev_addr_t  dev_addr,
    input  i2c_pkg::word_addr_t word_addr,
    input  i2c_pkg::data_t      wdata,
    output logic                xfer_done,
    output logic                xfer_error,
    output i2c_pkg::data_t      rdata,
    output logic                cmd_valid,
    output i2c_pkg::bit_cmd_t   cmd,
    output i2c_pkg::data_t      tx_byte,
    input  logic                cmd_done,
    input  logic                nack,
    input  i2c_pkg::data_t      rx_byte
);

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_dev_w,     // device address, write bit
        st_word,
        st_data,
        st_restart,
        st_dev_r,     // device address, read bit
        st_read,
        st_stop
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   err;           // a slave nacked somewhere in this transaction
    logic   outstanding;   // command issued, cmd_done not yet seen
    logic   wr_state;

    assign wr_state = state inside {st_dev_w, st_word, st_data, st_dev_r};

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (go) state_nxt = st_start;
            st_start:   if (cmd_done) state_nxt = st_dev_w;
            st_dev_w:   if (cmd_done) state_nxt = nack ? st_stop : st_word;
            st_word: begin
                if (cmd_done)
                    state_nxt = nack ? st_stop : (is_read ? st_restart : st_data);
            end
            st_data:    if (cmd_done) state_nxt = st_stop;
            st_restart: if (cmd_done) state_nxt = st_dev_r;
            st_dev_r:   if (cmd_done) state_nxt = nack ? st_stop : st_read;
            st_read:    if (cmd_done) state_nxt = st_stop;
            st_stop:    if (cmd_done) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= st_idle;
            cmd_valid   <= 1'b0;
            cmd         <= i2c_pkg::cmd_start;
            err         <= 1'b0;
            outstanding <= 1'b0;
            xfer_done   <= 1'b0;
            xfer_error  <= 1'b0;
        end else begin
            state      <= state_nxt;
            xfer_done  <= 1'b0;
            xfer_error <= 1'b0;
            // every state entered, except idle, issues exactly one command
            cmd_valid  <= (state_nxt != state) && (state_nxt != st_idle);
            case (state_nxt)
                st_start, st_restart: cmd <= i2c_pkg::cmd_start;
                st_stop:              cmd <= i2c_pkg::cmd_stop;
                st_read:              cmd <= i2c_pkg::cmd_read;
                default:              cmd <= i2c_pkg::cmd_write;
            endcase
            if (cmd_valid)
                outstanding <= 1'b1;
            else if (cmd_done)
                outstanding <= 1'b0;
            if (go)
                err <= 1'b0;
            else if (cmd_done && nack && wr_state)
                err <= 1'b1;
            if (state == st_stop && cmd_done) begin
                xfer_done  <= !err;
                xfer_error <= err;
            end
        end
    end

    // outgoing bytes and the captured read byte
    always_ff @(posedge clk) begin
        case (state_nxt)
            st_dev_w: tx_byte <= {dev_addr, 1'b0};
            st_word:  tx_byte <= word_addr;
            st_data:  tx_byte <= wdata;
            st_dev_r: tx_byte <= {dev_addr, 1'b1};
            default:  ;
        endcase
        if (state == st_read && cmd_done)
            rdata <= rx_byte;
    end

    one_cmd: assert property (@(posedge clk) disable iff (reset) cmd_valid |-> !outstanding);

endmodule

// ==== src/i2c_master_top.sv ====
module i2c_master_top #(
    parameter int clk_div = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  i2c_pkg::reg_addr_t wb_adr,
    input  i2c_pkg::data_t     wb_dat_w,
    output i2c_pkg::data_t     wb_dat_r,
    output logic               wb_ack,
    input  logic               scl_in,
    input  logic               sda_in,
    output logic               scl_oe,
    output logic               sda_oe
);

    // register block to sequencer
    logic                go;
    logic                is_read;
    i2c_pkg::dev_addr_t  dev_addr;
    i2c_pkg::word_addr_t word_addr;
    i2c_pkg::data_t      wdata;
    logic                xfer_done;
    logic                xfer_error;
    i2c_pkg::data_t      rdata;

    // sequencer to bit engine
    logic                cmd_valid;
    i2c_pkg::bit_cmd_t   cmd;
    i2c_pkg::data_t      tx_byte;
    logic                cmd_done;
    logic                nack;
    i2c_pkg::data_t      rx_byte;

    i2c_regs u_regs (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .go(go), .is_read(is_read), .dev_addr(dev_addr), .word_addr(word_addr),
        .wdata(wdata), .xfer_done(xfer_done), .xfer_error(xfer_error), .rdata(rdata)
    );

    i2c_sequencer u_seq (
        .clk(clk), .reset(reset),
        .go(go), .is_read(is_read), .dev_addr(dev_addr), .word_addr(word_addr),
        .wdata(wdata), .xfer_done(xfer_done), .xfer_error(xfer_error), .rdata(rdata),
        .cmd_valid(cmd_valid), .cmd(cmd), .tx_byte(tx_byte),
        .cmd_done(cmd_done), .nack(nack), .rx_byte(rx_byte)
    );

    i2c_bit_engine #(.clk_div(clk_div)) u_engine (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd(cmd), .tx_byte(tx_byte),
        .cmd_done(cmd_done), .nack(nack), .rx_byte(rx_byte),
        .sda_in(sda_in), .scl_in(scl_in), .scl_oe(scl_oe), .sda_oe(sda_oe)
    );

endmodule

// ==== tests/i2c_eeprom_model.sv ====
module i2c_eeprom_model #(
    parameter logic [6:0] slave_addr = 7'h50
) (
    input  logic scl,
    input  logic sda,
    output logic sda_oe      // 1 pulls sda low
);

    typedef enum {
        s_idle,
        s_addr,     // receiving the address byte
        s_word,     // receiving the word address
        s_data,     // receiving write data
        s_read      // sending memory bytes
    } state_t;

    state_t     state = s_idle;
    logic [7:0] mem [256];
    logic [7:0] sr;           // receive shift register
    logic [7:0] tx;           // byte being sent
    logic [7:0] ptr;          // memory pointer, advances per byte
    int         cnt;          // scl rising edges in this byte, 8 = ack clock
    logic       ack;
    logic       rw;

    initial begin
        sda_oe = 1'b0;
        sr     = 8'h00;
        tx     = 8'h00;
        ptr    = 8'h00;
        cnt    = 0;
        ack    = 1'b0;
        rw     = 1'b0;
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i);   // each byte starts as its own offset
    end

    ////////////////////////////////////////
    // bus conditions
    ////////////////////////////////////////

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            state = s_addr;
            cnt   = 0;
            ack   = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1)
            state = s_idle;   // stop
    end

    ////////////////////////////////////////
    // bit sampling on scl high
    ////////////////////////////////////////

    always @(posedge scl) begin
        if (state != s_idle) begin
            if (cnt < 8) begin
                if (state != s_read)
                    sr = {sr[6:0], sda};
                cnt = cnt + 1;
                if (cnt == 8) begin
                    case (state)
                        s_addr: begin
                            ack = (sr[7:1] == slave_addr);
                            rw  = sr[0];
                        end
                        s_word: begin
                            ptr = sr;
                            ack = 1'b1;
                        end
                        s_data: begin
                            mem[ptr] = sr;
                            ptr      = ptr + 8'd1;
                            ack      = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end else begin
                // ninth clock, acknowledge phase
                cnt = 0;
                case (state)
                    s_addr: state = !ack ? s_idle : (rw ? s_read : s_word);
                    s_word: state = s_data;
                    s_read: state = sda ? s_idle : s_read;   // master nack ends the read
                    default: ;
                endcase
                if (state == s_read) begin
                    tx  = mem[ptr];
                    ptr = ptr + 8'd1;
                end
            end
        end
    end

    // sda changes only while scl is low
    always @(negedge scl) begin : drive_sda
        logic drive;
        drive = 1'b0;
        if (cnt == 8 && ack && state inside {s_addr, s_word, s_data})
            drive = 1'b1;                        // slave ack
        else if (state == s_read && cnt < 8)
            drive = !tx[7 - cnt];                // msb first
        sda_oe = drive;
    end

endmodule

// ==== tests/tb_i2c_master.sv ====
module tb_i2c_master;

    localparam int clk_div   = 4;
    localparam int period    = 4;
    localparam int num_xfers = 47;                       // i2c transactions over all tests
    localparam int max_xfer  = 4 * 9 * 4 * clk_div * 2;  // 4 frames of 9 bits, doubled
    localparam i2c_pkg::dev_addr_t slave_addr = 7'h50;

    localparam i2c_pkg::data_t go_write = 8'h01 << i2c_pkg::ctrl_go_bit;
    localparam i2c_pkg::data_t go_read  = go_write | (8'h01 << i2c_pkg::ctrl_read_bit);
    localparam i2c_pkg::data_t st_busy  = 8'h01 << i2c_pkg::status_busy_bit;
    localparam i2c_pkg::data_t st_done  = 8'h01 << i2c_pkg::status_done_bit;
    localparam i2c_pkg::data_t st_error = 8'h01 << i2c_pkg::status_error_bit;

    logic               clk;
    logic               reset;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    i2c_pkg::reg_addr_t wb_adr;
    i2c_pkg::data_t     wb_dat_w;
    i2c_pkg::data_t     wb_dat_r;
    logic               wb_ack;
    logic               scl_oe;
    logic               sda_oe;
    logic               slave_sda_oe;
    wire                scl_line;
    wire                sda_line;

    assign scl_line = ~scl_oe;                   // pull-up, only the master drives scl
    assign sda_line = ~(sda_oe | slave_sda_oe);  // wired-AND

    i2c_master_top #(.clk_div(clk_div)) dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .scl_in(scl_line), .sda_in(sda_line), .scl_oe(scl_oe), .sda_oe(sda_oe)
    );

    i2c_eeprom_model #(.slave_addr(slave_addr)) u_eeprom (
        .scl(scl_line), .sda(sda_line), .sda_oe(slave_sda_oe)
    );

    integer         seed = 54;
    i2c_pkg::data_t ref_mem [256];   // mirror of the eeprom contents
    int             errors;
    int             test_errors;     // error count when the current test began
    int             pass_cnt;
    int             fail_cnt;

    always #(period / 2) clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_byte(input string name, input i2c_pkg::data_t exp,
                                input i2c_pkg::data_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %02h, actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic bus_access(input logic we, input i2c_pkg::reg_addr_t adr,
                              input i2c_pkg::data_t dat, output i2c_pkg::data_t rdat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do
            @(posedge clk);
        while (!wb_ack);
        rdat = wb_dat_r;   // value of the ack cycle
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input i2c_pkg::reg_addr_t adr, input i2c_pkg::data_t dat);
        i2c_pkg::data_t discard;
        bus_access(1'b1, adr, dat, discard);
    endtask

    task automatic bus_read(input i2c_pkg::reg_addr_t adr, output i2c_pkg::data_t dat);
        bus_access(1'b0, adr, 8'h00, dat);
    endtask

    task automatic wait_idle(output i2c_pkg::data_t status);
        do
            bus_read(i2c_pkg::reg_status, status);
        while (status[i2c_pkg::status_busy_bit]);
    endtask

    task automatic run_xfer(input i2c_pkg::dev_addr_t dev, input i2c_pkg::word_addr_t off,
                            input i2c_pkg::data_t dat, input logic rd,
                            output i2c_pkg::data_t status, output i2c_pkg::data_t rdat);
        bus_write(i2c_pkg::reg_dev_addr, {1'b0, dev});
        bus_write(i2c_pkg::reg_word_addr, off);
        bus_write(i2c_pkg::reg_wdata, dat);
        bus_write(i2c_pkg::reg_ctrl, rd ? go_read : go_write);
        wait_idle(status);
        rdat = 8'h00;
        if (rd)
            bus_read(i2c_pkg::reg_rdata, rdat);
        if (!rd && dev == slave_addr)
            ref_mem[off] = dat;   // only the addressed eeprom takes the byte
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin : stimulus
        i2c_pkg::data_t      st;
        i2c_pkg::data_t      rd;
        i2c_pkg::data_t      v;
        i2c_pkg::data_t      dat;
        i2c_pkg::word_addr_t off;
        i2c_pkg::word_addr_t off2;
        i2c_pkg::dev_addr_t  bad;
        logic                is_rd;

        clk         = 1'b0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        errors      = 0;
        test_errors = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        for (int i = 0; i < 256; i++)
            ref_mem[i] = i2c_pkg::data_t'(i);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        repeat (4) begin
            v = i2c_pkg::data_t'($random(seed));
            bus_write(i2c_pkg::reg_dev_addr, v);
            bus_read(i2c_pkg::reg_dev_addr, rd);
            compare_byte("dev_addr read-back", {1'b0, v[6:0]}, rd);
            v = i2c_pkg::data_t'($random(seed));
            bus_write(i2c_pkg::reg_word_addr, v);
            bus_read(i2c_pkg::reg_word_addr, rd);
            compare_byte("word_addr read-back", v, rd);
            v = i2c_pkg::data_t'($random(seed));
            bus_write(i2c_pkg::reg_wdata, v);
            bus_read(i2c_pkg::reg_wdata, rd);
            compare_byte("wdata read-back", v, rd);
        end
        end_test("register read-back");

        off = i2c_pkg::word_addr_t'($random(seed));
        dat = i2c_pkg::data_t'($random(seed));
        run_xfer(slave_addr, off, dat, 1'b0, st, rd);
        compare_byte("byte write status", st_done, st);
        run_xfer(slave_addr, off, 8'h00, 1'b1, st, rd);
        compare_byte("random read data", dat, rd);
        compare_byte("random read status", st_done, st);
        end_test("write then read");

        for (int n = 0; n < 40; n++) begin
            is_rd = 1'($random(seed));
            off   = i2c_pkg::word_addr_t'($random(seed));
            dat   = i2c_pkg::data_t'($random(seed));
            run_xfer(slave_addr, off, dat, is_rd, st, rd);
            compare_byte("random transaction status", st_done, st);
            if (is_rd)
                compare_byte("random transaction read", ref_mem[off], rd);
        end
        end_test("random transactions");

        // nobody answers, so the write must not land
        bad = i2c_pkg::dev_addr_t'($random(seed));
        if (bad == slave_addr)
            bad = bad ^ 7'h01;
        off = i2c_pkg::word_addr_t'($random(seed));
        dat = ~ref_mem[off];
        run_xfer(bad, off, dat, 1'b0, st, rd);
        compare_byte("nack status", st_error, st);
        run_xfer(slave_addr, off, 8'h00, 1'b1, st, rd);
        compare_byte("memory after nack", ref_mem[off], rd);
        end_test("address nack");

        off  = i2c_pkg::word_addr_t'($random(seed));
        off2 = off ^ 8'h80;
        dat  = i2c_pkg::data_t'($random(seed));
        bus_write(i2c_pkg::reg_dev_addr, {1'b0, slave_addr});
        bus_write(i2c_pkg::reg_word_addr, off);
        bus_write(i2c_pkg::reg_wdata, dat);
        bus_write(i2c_pkg::reg_ctrl, go_write);
        bus_read(i2c_pkg::reg_status, st);
        compare_byte("status right after go", st_busy, st);
        bus_write(i2c_pkg::reg_word_addr, off2);   // ignored while busy
        bus_write(i2c_pkg::reg_ctrl, go_write);
        wait_idle(st);
        compare_byte("first transaction status", st_done, st);
        ref_mem[off] = dat;
        run_xfer(slave_addr, off, 8'h00, 1'b1, st, rd);
        compare_byte("first offset after busy go", ref_mem[off], rd);
        run_xfer(slave_addr, off2, 8'h00, 1'b1, st, rd);
        compare_byte("second offset after busy go", ref_mem[off2], rd);
        end_test("control write while busy");

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : watchdog
        #(num_xfers * max_xfer * period);
        $display("timeout: the transactions did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== compile.f ====
src/i2c_pkg.sv
src/i2c_regs.sv
src/i2c_bit_engine.sv
src/i2c_sequencer.sv
src/i2c_master_top.sv
tests/i2c_eeprom_model.sv
tests/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - src/i2c_pkg.sv
  - src/i2c_regs.sv
  - src/i2c_bit_engine.sv
  - src/i2c_sequencer.sv
  - src/i2c_master_top.sv
  - target: test
    files:
      - tests/i2c_eeprom_model.sv
      - tests/tb_i2c_master.sv
